/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_op
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary -j 0 -Wno-fatal

SRCS := $(wildcard source/*.sv) sim/tb_op.sv sim/tb_op_table.svh
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) tb.f
	$(VERILATOR) $(VFLAGS) -f tb.f --top-module $(TOP) -Mdir $(OBJ_DIR)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -qxF '** PASS **' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* sim/tb_op_table.svh */
`ifndef TB_OP_TABLE_SVH
`define TB_OP_TABLE_SVH

////////////////////
// stimulus table

typedef struct {
    string          name;
    op_pkg::a_vec_t a;
    op_pkg::b_vec_t b;
    bit             sat;      // saturate mode
    int             ack_dly;  // cycles out_ack is held back
    bit             b_first;
} entry_t;

localparam int N_FIXED   = 6;
localparam int N_RAND    = 8;
localparam int N_ENTRIES = N_FIXED + N_RAND;

entry_t      tbl [$];
logic [31:0] rng = 32'hd131;

function automatic logic [31:0] xorshift(input logic [31:0] s);
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
endfunction

function automatic void add_entry(input string name, input logic [31:0] a, input logic [31:0] b,
                                  input bit sat, input int dly, input bit b_first);
    tbl.push_back(entry_t'{name, a, b, sat, dly, b_first});
endfunction

function automatic void load_table();
    logic [31:0] ra;
    logic [31:0] rb;
    add_entry("in_range_wrap",     32'h10_08_f0_04, 32'h10_20_f8_02, 1'b0, 0, 1'b0);
    add_entry("overflow_wrap",     32'h7f_80_40_20, 32'h7f_80_30_01, 1'b0, 0, 1'b0);
    add_entry("overflow_sat",      32'h7f_80_40_20, 32'h7f_80_30_01, 1'b1, 0, 1'b0);
    add_entry("b_before_a",        32'h10_08_f0_04, 32'h10_20_f8_02, 1'b0, 0, 1'b1);
    add_entry("ack_delay_sat",     32'h7f_80_40_20, 32'h7f_80_30_01, 1'b1, 6, 1'b0);
    add_entry("ack_delay_b_first", 32'h10_08_f0_04, 32'h10_20_f8_02, 1'b0, 3, 1'b1);
    for (int k = 0; k < N_RAND; k++) begin
        rng = xorshift(rng);
        ra  = rng;
        rng = xorshift(rng);
        rb  = rng;
        // small b on odd entries keeps every cell in range
        add_entry($sformatf("random_%0d", k), ra, (k % 2 == 1) ? (rb & 32'h0f0f0f0f) : rb,
                  ((k / 2) % 2 == 1), 0, ra[0]);
    end
endfunction

// shifted signed product, then range test, clamp or wrap
function automatic op_pkg::result_t ref_result(input op_pkg::a_vec_t a, input op_pkg::b_vec_t b,
                                               input bit sat);
    op_pkg::result_t r;
    int              p;
    int              hi;
    int              lo;
    hi = (1 << (op_pkg::RES_W - 1)) - 1;
    lo = -(1 << (op_pkg::RES_W - 1));
    r  = '0;
    for (int i = 0; i < op_pkg::A_LEN; i++) begin
        for (int j = 0; j < op_pkg::B_LEN; j++) begin
            p = (int'($signed(a[i])) * int'($signed(b[j]))) >>> op_pkg::FRAC_W;
            if (p > hi || p < lo) begin
                r.error = 1'b1;
                if (sat) p = (p > hi) ? hi : lo;
            end
            r.cells[i][j] = op_pkg::RES_W'(p);
        end
    end
    return r;
endfunction

`endif

/* sim/tb_op.sv */
`timescale 1ns/100ps

module tb_op;

    logic                      clk = 1'b0;
    logic                      rst;
    logic                      a_req;
    op_pkg::a_vec_t            a_data;
    logic                      a_ack;
    logic                      b_req;
    op_pkg::b_vec_t            b_data;
    logic                      b_ack;
    logic                      out_req;
    op_pkg::result_t           out_data;
    logic                      out_ack;
    op_pkg::cfg_wr_t           cfg_wr;
    logic [op_pkg::CFG_AW-1:0] cfg_rd_addr;
    logic [op_pkg::CFG_DW-1:0] cfg_rd_data;

    int n_checks = 0;
    int n_errors = 0;
    int n_ovf    = 0;  // results with the reference error bit
    int cycles   = 0;

    `include "tb_op_table.svh"

    localparam int CMP_W          = $bits(op_pkg::result_t);
    localparam int TIMEOUT_CYCLES = N_ENTRIES * 60;

    op_top dut_i (.*);

    always #20 clk = ~clk;

    ////////////////////
    // watchdog

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: a handshake did not finish within %0d cycles", cycles);
            $display("** FAIL **");
            $finish;
        end
    end

    ////////////////////
    // helpers

    task automatic compare(input string name, input logic [CMP_W-1:0] exp,
                           input logic [CMP_W-1:0] act);
        n_checks++;
        if (act !== exp) begin
            n_errors++;
            $display("Fail %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic write_cfg(input logic [op_pkg::CFG_AW-1:0] addr,
                             input logic [op_pkg::CFG_DW-1:0] data);
        cfg_wr = '{en: 1'b1, addr: addr, data: data};
        @(negedge clk);
        cfg_wr.en = 1'b0;
    endtask

    // one full four-phase transfer on the a or b port
    task automatic send_vec(input bit is_b, input logic [31:0] data);
        if (is_b) begin
            b_data = data;
            b_req  = 1'b1;
        end else begin
            a_data = data;
            a_req  = 1'b1;
        end
        do @(negedge clk); while (!(is_b ? b_ack : a_ack));
        if (is_b) b_req = 1'b0;
        else      a_req = 1'b0;
        do @(negedge clk); while (is_b ? b_ack : a_ack);
    endtask

    task automatic send_pair(input op_pkg::a_vec_t a, input op_pkg::b_vec_t b, input bit b_first);
        if (b_first) begin
            send_vec(1'b1, b);
            send_vec(1'b0, a);
        end else begin
            send_vec(1'b0, a);
            send_vec(1'b1, b);
        end
    endtask

    task automatic receive_result(input string name, input op_pkg::result_t exp, input int dly,
                                  input bit blocked);
        while (!out_req) @(negedge clk);
        compare(name, exp, out_data);
        repeat (dly) begin
            @(negedge clk);
            if (blocked) compare({name, " a_ack stalled"}, '0, CMP_W'(a_ack));
        end
        out_ack = 1'b1;
        while (out_req) @(negedge clk);
        out_ack = 1'b0;
        if (exp.error) n_ovf++;
    endtask

    ////////////////////
    // main sequence

    initial begin
        entry_t          e;
        op_pkg::result_t exp;
        rst         = 1'b1;
        a_req       = 1'b0;
        a_data      = '0;
        b_req       = 1'b0;
        b_data      = '0;
        out_ack     = 1'b0;
        cfg_wr      = '0;
        cfg_rd_addr = op_pkg::CFG_OVF_CNT;
        load_table();
        repeat (4) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        compare("reset a_ack", '0, CMP_W'(a_ack));
        compare("reset b_ack", '0, CMP_W'(b_ack));
        compare("reset out_req", '0, CMP_W'(out_req));
        compare("reset ovf_count", '0, CMP_W'(cfg_rd_data));

        foreach (tbl[k]) begin
            e   = tbl[k];
            exp = ref_result(e.a, e.b, e.sat);
            write_cfg(op_pkg::CFG_MODE, op_pkg::CFG_DW'(e.sat));
            cfg_rd_addr = op_pkg::CFG_MODE;  // read the mode back
            @(negedge clk);
            compare({e.name, " mode"}, CMP_W'(e.sat), CMP_W'(cfg_rd_data));
            cfg_rd_addr = op_pkg::CFG_OVF_CNT;
            send_pair(e.a, e.b, e.b_first);
            if (e.ack_dly > 0) begin
                // engine and both ports fill up behind the held result
                send_pair(e.a, e.b, e.b_first);
                send_pair(e.a, e.b, e.b_first);
                a_data = e.a;
                a_req  = 1'b1;  // must stall until out_ack
                receive_result(e.name, exp, e.ack_dly, 1'b1);
                while (!a_ack) @(negedge clk);
                a_req = 1'b0;
                while (a_ack) @(negedge clk);
                send_vec(1'b1, e.b);
                repeat (3) receive_result(e.name, exp, 0, 1'b0);
            end else begin
                receive_result(e.name, exp, 0, 1'b0);
            end
        end

        compare("ovf_count", CMP_W'(n_ovf), CMP_W'(cfg_rd_data));
        write_cfg(op_pkg::CFG_OVF_CNT, '0);
        compare("ovf_count cleared", '0, CMP_W'(cfg_rd_data));

        $display("checks %0d, errors %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

/* source/op_config.sv */
`timescale 1ns/100ps

// mode register and overflow counter
module op_config (
    input  logic                      clk,
    input  logic                      rst,
    input  op_pkg::cfg_wr_t           cfg_wr,
    input  logic [op_pkg::CFG_AW-1:0] cfg_rd_addr,
    output logic [op_pkg::CFG_DW-1:0] cfg_rd_data,
    output logic                      saturate,
    input  logic                      ovf_event
);

    logic [op_pkg::CFG_DW-1:0] ovf_cnt;
    logic                      mode_wr;
    logic                      cnt_wr;

    assign mode_wr = cfg_wr.en && (cfg_wr.addr == op_pkg::CFG_MODE);
    assign cnt_wr  = cfg_wr.en && (cfg_wr.addr == op_pkg::CFG_OVF_CNT);

    ////////////////////
    // registers

    always_ff @(posedge clk) begin
        if (rst) begin
            saturate <= 1'b0;  // wrap
            ovf_cnt  <= '0;
        end else begin
            if (mode_wr) begin
                saturate <= cfg_wr.data[0];
            end

            // clear wins over a same-cycle event
            if (cnt_wr) begin
                ovf_cnt <= '0;
            end else if (ovf_event && (ovf_cnt != '1)) begin
                ovf_cnt <= ovf_cnt + 1'b1;  // sticks at max
            end
        end
    end

    ////////////////////
    // read mux

    always_comb begin
        case (cfg_rd_addr)
            op_pkg::CFG_MODE:    cfg_rd_data = {{(op_pkg::CFG_DW-1){1'b0}}, saturate};
            op_pkg::CFG_OVF_CNT: cfg_rd_data = ovf_cnt;
            default:             cfg_rd_data = '0;  // unmapped
        endcase
    end

endmodule

/* source/op_pkg.sv */
package op_pkg;

    ////////////////////
    // sizing

    localparam int A_LEN  = 4;  // elements in a
    localparam int B_LEN  = 4;  // elements in b
    localparam int A_W    = 8;
    localparam int B_W    = 8;
    localparam int RES_W  = 8;  // result cell width
    localparam int FRAC_W = 4;  // fraction bits, same for a, b and result
    localparam int TILE_V = 1;  // a rows per step
    localparam int TILE_H = 2;  // b columns per step

    localparam int PROD_W = A_W + B_W;

    // tile counts, rounded up so a partial last tile still gets a step
    localparam int ROW_STEPS   = (A_LEN + TILE_V - 1) / TILE_V;
    localparam int COL_STEPS   = (B_LEN + TILE_H - 1) / TILE_H;
    localparam int CALC_CYCLES = ROW_STEPS * COL_STEPS;

    localparam int ROW_CW = (ROW_STEPS > 1) ? $clog2(ROW_STEPS) : 1;
    localparam int COL_CW = (COL_STEPS > 1) ? $clog2(COL_STEPS) : 1;

    // config register file
    localparam int CFG_AW = 2;
    localparam int CFG_DW = 16;

    localparam logic [CFG_AW-1:0] CFG_MODE    = 2'd0;  // bit 0 set = saturate
    localparam logic [CFG_AW-1:0] CFG_OVF_CNT = 2'd1;  // overflow count, write clears

    ////////////////////
    // types

    typedef logic [A_LEN-1:0][A_W-1:0] a_vec_t;
    typedef logic [B_LEN-1:0][B_W-1:0] b_vec_t;

    // row i holds a[i] times every b[j]
    typedef logic [A_LEN-1:0][B_LEN-1:0][RES_W-1:0] cells_t;

    typedef struct packed {
        cells_t cells;
        logic   error;  // any cell out of range
    } result_t;

    typedef struct packed {
        logic              en;
        logic [CFG_AW-1:0] addr;
        logic [CFG_DW-1:0] data;
    } cfg_wr_t;

endpackage

/* source/op_top.sv */
`timescale 1ns/100ps

module op_top (
    input  logic                      clk,
    input  logic                      rst,
    // a vector
    input  logic                      a_req,
    input  op_pkg::a_vec_t            a_data,
    output logic                      a_ack,
    // b vector
    input  logic                      b_req,
    input  op_pkg::b_vec_t            b_data,
    output logic                      b_ack,
    // result matrix
    output logic                      out_req,
    output op_pkg::result_t           out_data,
    input  logic                      out_ack,
    // config
    input  op_pkg::cfg_wr_t           cfg_wr,
    input  logic [op_pkg::CFG_AW-1:0] cfg_rd_addr,
    output logic [op_pkg::CFG_DW-1:0] cfg_rd_data
);

    logic            a_full;
    logic            b_full;
    op_pkg::a_vec_t  a_val;
    op_pkg::b_vec_t  b_val;
    logic            take;       // empties both ports
    logic            saturate;
    logic            res_valid;
    op_pkg::result_t res;
    logic            res_taken;
    logic            ovf_event;

    ////////////////////
    // input ports

    vec_port #(.payload_t(op_pkg::a_vec_t)) a_port_i (
        .clk   (clk),
        .rst   (rst),
        .req   (a_req),
        .data  (a_data),
        .ack   (a_ack),
        .take  (take),
        .full  (a_full),
        .value (a_val)
    );

    vec_port #(.payload_t(op_pkg::b_vec_t)) b_port_i (
        .clk   (clk),
        .rst   (rst),
        .req   (b_req),
        .data  (b_data),
        .ack   (b_ack),
        .take  (take),
        .full  (b_full),
        .value (b_val)
    );

    ////////////////////
    // engine, config, output

    outer_product outer_product_i (
        .clk       (clk),
        .rst       (rst),
        .a_full    (a_full),
        .a_val     (a_val),
        .b_full    (b_full),
        .b_val     (b_val),
        .take      (take),
        .saturate  (saturate),
        .res_valid (res_valid),
        .res       (res),
        .res_taken (res_taken),
        .ovf_event (ovf_event)
    );

    op_config op_config_i (
        .clk         (clk),
        .rst         (rst),
        .cfg_wr      (cfg_wr),
        .cfg_rd_addr (cfg_rd_addr),
        .cfg_rd_data (cfg_rd_data),
        .saturate    (saturate),
        .ovf_event   (ovf_event)
    );

    result_port result_port_i (
        .clk       (clk),
        .rst       (rst),
        .res_valid (res_valid),
        .res       (res),
        .res_taken (res_taken),
        .out_req   (out_req),
        .out_data  (out_data),
        .out_ack   (out_ack)
    );

endmodule

/* source/outer_product.sv */
`timescale 1ns/100ps

// tiled signed outer product, one tile per cycle
module outer_product (
    input  logic             clk,
    input  logic             rst,
    input  logic             a_full,
    input  op_pkg::a_vec_t   a_val,
    input  logic             b_full,
    input  op_pkg::b_vec_t   b_val,
    output logic             take,
    input  logic             saturate,
    output logic             res_valid,
    output op_pkg::result_t  res,
    input  logic             res_taken,
    output logic             ovf_event
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_CALC,
        ST_DONE
    } state_t;

    state_t state;

    op_pkg::a_vec_t a_buf;
    op_pkg::b_vec_t b_buf;
    op_pkg::cells_t cells_q;
    logic           err_q;

    logic [op_pkg::ROW_CW-1:0] row_cnt;
    logic [op_pkg::COL_CW-1:0] col_cnt;
    logic                      last_row;
    logic                      last_col;

    ////////////////////
    // tile datapath

    logic [op_pkg::TILE_V-1:0][op_pkg::A_W-1:0] tile_a;
    logic [op_pkg::TILE_H-1:0][op_pkg::B_W-1:0] tile_b;
    logic [op_pkg::TILE_V-1:0]                  tile_a_hit;  // slot maps to a real a[i]
    logic [op_pkg::TILE_H-1:0]                  tile_b_hit;

    logic signed [op_pkg::PROD_W-1:0] tile_shift [op_pkg::TILE_V][op_pkg::TILE_H];
    logic        [op_pkg::RES_W-1:0]  tile_cell  [op_pkg::TILE_V][op_pkg::TILE_H];
    logic [op_pkg::TILE_V-1:0][op_pkg::TILE_H-1:0] tile_ovf;
    logic                                          tile_err;

    // pick the operands of the current tile, slots past the end stay zero
    always_comb begin
        tile_a     = '0;
        tile_a_hit = '0;
        for (int i = 0; i < op_pkg::A_LEN; i++) begin
            if (int'(row_cnt) == i / op_pkg::TILE_V) begin
                tile_a[i % op_pkg::TILE_V]     = a_buf[i];
                tile_a_hit[i % op_pkg::TILE_V] = 1'b1;
            end
        end
        tile_b     = '0;
        tile_b_hit = '0;
        for (int j = 0; j < op_pkg::B_LEN; j++) begin
            if (int'(col_cnt) == j / op_pkg::TILE_H) begin
                tile_b[j % op_pkg::TILE_H]     = b_buf[j];
                tile_b_hit[j % op_pkg::TILE_H] = 1'b1;
            end
        end
    end

    always_comb begin
        tile_err = 1'b0;
        for (int k = 0; k < op_pkg::TILE_V; k++) begin
            for (int l = 0; l < op_pkg::TILE_H; l++) begin
                tile_shift[k][l] = op_pkg::PROD_W'($signed(tile_a[k]) * $signed(tile_b[l]))
                                   >>> op_pkg::FRAC_W;
                // out of range unless the bits from the result sign up all agree
                tile_ovf[k][l] =
                    !((&tile_shift[k][l][op_pkg::PROD_W-1:op_pkg::RES_W-1]) ||
                      !(|tile_shift[k][l][op_pkg::PROD_W-1:op_pkg::RES_W-1]));
                if (tile_ovf[k][l] && saturate) begin
                    // negative -> 0x80, positive -> 0x7f
                    tile_cell[k][l] = {tile_shift[k][l][op_pkg::PROD_W-1],
                                       {(op_pkg::RES_W-1){~tile_shift[k][l][op_pkg::PROD_W-1]}}};
                end else begin
                    tile_cell[k][l] = tile_shift[k][l][op_pkg::RES_W-1:0];  // wrap
                end
                if (tile_ovf[k][l] && tile_a_hit[k] && tile_b_hit[l]) begin
                    tile_err = 1'b1;
                end
            end
        end
    end

    ////////////////////
    // control

    assign take     = (state == ST_IDLE) && a_full && b_full;
    assign last_row = int'(row_cnt) == op_pkg::ROW_STEPS - 1;
    assign last_col = int'(col_cnt) == op_pkg::COL_STEPS - 1;

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= ST_IDLE;
            row_cnt   <= '0;
            col_cnt   <= '0;
            err_q     <= 1'b0;
            ovf_event <= 1'b0;
        end else begin
            ovf_event <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (take) begin
                        state   <= ST_CALC;
                        row_cnt <= '0;
                        col_cnt <= '0;
                        err_q   <= 1'b0;  // fresh error per result
                    end
                end
                ST_CALC: begin
                    err_q <= err_q | tile_err;
                    if (last_col) begin
                        col_cnt <= '0;
                        if (last_row) begin
                            state     <= ST_DONE;
                            row_cnt   <= '0;
                            ovf_event <= err_q | tile_err;  // one pulse per bad result
                        end else begin
                            row_cnt <= row_cnt + 1'b1;
                        end
                    end else begin
                        col_cnt <= col_cnt + 1'b1;  // columns inner
                    end
                end
                ST_DONE: begin
                    if (res_taken) begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // operand copies, ports are free again after take
    always_ff @(posedge clk) begin
        if (take) begin
            a_buf <= a_val;
            b_buf <= b_val;
        end
    end

    // store the cells of the active tile
    always_ff @(posedge clk) begin
        if (state == ST_CALC) begin
            for (int i = 0; i < op_pkg::A_LEN; i++) begin
                for (int j = 0; j < op_pkg::B_LEN; j++) begin
                    if (int'(row_cnt) == i / op_pkg::TILE_V &&
                        int'(col_cnt) == j / op_pkg::TILE_H) begin
                        cells_q[i][j] <= tile_cell[i % op_pkg::TILE_V][j % op_pkg::TILE_H];
                    end
                end
            end
        end
    end

    assign res_valid = (state == ST_DONE);
    assign res       = '{cells: cells_q, error: err_q};

endmodule

/* source/result_port.sv */
`timescale 1ns/100ps

// four-phase sender for the finished matrix
module result_port (
    input  logic            clk,
    input  logic            rst,
    input  logic            res_valid,
    input  op_pkg::result_t res,
    output logic            res_taken,
    output logic            out_req,
    output op_pkg::result_t out_data,
    input  logic            out_ack
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_SEND,     // req high, wait for ack
        ST_RELEASE   // req low, wait for ack to drop
    } state_t;

    state_t state;
    logic   latch;

    assign latch = (state == ST_IDLE) && res_valid;

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= ST_IDLE;
            res_taken <= 1'b0;
        end else begin
            res_taken <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (latch) begin
                        state     <= ST_SEND;
                        res_taken <= 1'b1;  // engine may start over
                    end
                end
                ST_SEND:    if (out_ack)  state <= ST_RELEASE;
                ST_RELEASE: if (!out_ack) state <= ST_IDLE;
                default:    state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (latch) begin
            out_data <= res;
        end
    end

    assign out_req = (state == ST_SEND);

endmodule

/* source/vec_port.sv */
`timescale 1ns/100ps

// four-phase receiver with a single holding register
module vec_port #(
    parameter type payload_t = op_pkg::a_vec_t
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     req,
    input  payload_t data,
    output logic     ack,
    input  logic     take,   // engine has copied the value
    output logic     full,
    output payload_t value
);

    logic accept;

    // new vector only while empty and the previous handshake is closed
    assign accept = req && !ack && !full;

    always_ff @(posedge clk) begin
        if (rst) begin
            ack  <= 1'b0;
            full <= 1'b0;
        end else begin
            if (accept) begin
                ack  <= 1'b1;
                full <= 1'b1;
            end else if (ack && !req) begin
                ack <= 1'b0;  // phase 4
            end

            if (take) begin
                full <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            value <= data;
        end
    end

endmodule

/* tb.f */
+incdir+sim
source/op_pkg.sv
source/vec_port.sv
source/outer_product.sv
source/op_config.sv
source/result_port.sv
source/op_top.sv
sim/tb_op.sv
